// File: hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

  localparam int XLEN    = 32;
  localparam int REG_AW  = 5;
  localparam int REG_NUM = 2 ** REG_AW;

  // instruction field widths
  localparam int OP_W   = 6;
  localparam int FN_W   = 6;
  localparam int SH_W   = 5;
  localparam int IMM_W  = 16;
  localparam int JIDX_W = 26;
  localparam int ALU_W  = 4;

  localparam int DMEM_WORDS = 64;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  localparam logic [XLEN-1:0] RESET_PC = '0;
  localparam logic [XLEN-1:0] PC_STEP  = 4;

  // primary opcodes
  localparam logic [OP_W-1:0] OP_RTYPE = 6'h00;
  localparam logic [OP_W-1:0] OP_J     = 6'h02;
  localparam logic [OP_W-1:0] OP_BEQ   = 6'h04;
  localparam logic [OP_W-1:0] OP_BNE   = 6'h05;
  localparam logic [OP_W-1:0] OP_ADDI  = 6'h08;
  localparam logic [OP_W-1:0] OP_ADDIU = 6'h09;
  localparam logic [OP_W-1:0] OP_ANDI  = 6'b001100;
  localparam logic [OP_W-1:0] OP_ORI   = 6'b001101;
  localparam logic [OP_W-1:0] OP_XORI  = 6'b001110;
  localparam logic [OP_W-1:0] OP_LUI   = 6'b001111;
  localparam logic [OP_W-1:0] OP_COP0  = 6'b010000;
  localparam logic [OP_W-1:0] OP_LW    = 6'h23;
  localparam logic [OP_W-1:0] OP_SW    = 6'h2b;

  // r-type function field
  localparam logic [FN_W-1:0] FN_SLL  = 6'h00;
  localparam logic [FN_W-1:0] FN_SRL  = 6'h02;
  localparam logic [FN_W-1:0] FN_ADD  = 6'h20;
  localparam logic [FN_W-1:0] FN_ADDU = 6'h21;
  localparam logic [FN_W-1:0] FN_SUB  = 6'h22;
  localparam logic [FN_W-1:0] FN_SUBU = 6'h23;
  localparam logic [FN_W-1:0] FN_AND  = 6'h24;
  localparam logic [FN_W-1:0] FN_OR   = 6'h25;
  localparam logic [FN_W-1:0] FN_XOR  = 6'h26;
  localparam logic [FN_W-1:0] FN_NOR  = 6'h27;
  localparam logic [FN_W-1:0] FN_SLT  = 6'h2a;
  localparam logic [FN_W-1:0] FN_SLTU = 6'h2b;

  // internal alu operations
  localparam logic [ALU_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_W-1:0] ALU_AND  = 4'd2;
  localparam logic [ALU_W-1:0] ALU_OR   = 4'd3;
  localparam logic [ALU_W-1:0] ALU_XOR  = 4'd4;
  localparam logic [ALU_W-1:0] ALU_NOR  = 4'd5;
  localparam logic [ALU_W-1:0] ALU_SLT  = 4'd6;
  localparam logic [ALU_W-1:0] ALU_SLTU = 4'd7;
  localparam logic [ALU_W-1:0] ALU_SLL  = 4'd8;
  localparam logic [ALU_W-1:0] ALU_SRL  = 4'd9;
  localparam logic [ALU_W-1:0] ALU_LUI  = 4'd10;

endpackage

`default_nettype wire

// File: hdl/control.sv
`default_nettype none
`timescale 1ns/1ns

module control
(
  input  wire  [mips_pkg::OP_W-1:0] i_instr_code,
  output logic                      o_reg_dst,
  output logic                      o_jump,
  output logic                      o_beq,
  output logic                      o_bne,
  output logic                      o_mem_to_reg,
  output logic [mips_pkg::OP_W-1:0] o_alu_op,
  output logic                      o_mem_write,
  output logic                      o_alu_src_op2,
  output logic                      o_reg_write,
  output logic                      o_ext_op,
  output logic                      o_unknown_command
);

  always_comb
  begin
    o_reg_dst         = 1'b0;
    o_jump            = 1'b0;
    o_beq             = 1'b0;
    o_bne             = 1'b0;
    o_mem_to_reg      = 1'b0;
    o_alu_op          = i_instr_code; // alu decodes the opcode itself
    o_mem_write       = 1'b0;
    o_alu_src_op2     = 1'b0;
    o_reg_write       = 1'b0;
    o_ext_op          = 1'b0;
    o_unknown_command = 1'b0;

    case (i_instr_code)
      mips_pkg::OP_RTYPE:
      begin
        o_reg_dst   = 1'b1;
        o_reg_write = 1'b1;
      end
      mips_pkg::OP_ADDI,
      mips_pkg::OP_ADDIU:
      begin
        o_reg_write   = 1'b1;
        o_alu_src_op2 = 1'b1;
        o_ext_op      = 1'b1;
      end
      mips_pkg::OP_LUI,
      mips_pkg::OP_ORI,
      mips_pkg::OP_XORI,
      mips_pkg::OP_ANDI:
      begin
        o_reg_write   = 1'b1;
        o_alu_src_op2 = 1'b1; // zero-extended immediate
      end
      mips_pkg::OP_LW:
      begin
        o_reg_write   = 1'b1;
        o_alu_src_op2 = 1'b1;
        o_mem_to_reg  = 1'b1;
        o_ext_op      = 1'b1;
      end
      mips_pkg::OP_SW:
      begin
        o_alu_src_op2 = 1'b1;
        o_mem_write   = 1'b1;
        o_ext_op      = 1'b1;
      end
      mips_pkg::OP_J:    o_jump = 1'b1;
      mips_pkg::OP_BEQ:  o_beq  = 1'b1;
      mips_pkg::OP_BNE:  o_bne  = 1'b1;
      mips_pkg::OP_COP0: o_jump = 1'b0; // legal no-op
      default:           o_unknown_command = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/alu.sv
`default_nettype none
`timescale 1ns/1ns

module alu
(
  input  wire  [mips_pkg::OP_W-1:0]  i_alu_op,
  input  wire  [mips_pkg::FN_W-1:0]  i_funct,
  input  wire  [mips_pkg::SH_W-1:0]  i_shamt,
  input  wire  [mips_pkg::XLEN-1:0]  i_a,
  input  wire  [mips_pkg::XLEN-1:0]  i_b,
  output logic [mips_pkg::XLEN-1:0]  o_result,
  output logic                       o_zero
);

  logic [mips_pkg::ALU_W-1:0] op_sel;
  logic                       op_ok;

  // opcode and funct to internal operation
  always_comb
  begin
    op_sel = mips_pkg::ALU_ADD;
    op_ok  = 1'b1;
    case (i_alu_op)
      mips_pkg::OP_RTYPE:
      begin
        case (i_funct)
          mips_pkg::FN_ADD,
          mips_pkg::FN_ADDU: op_sel = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUB,
          mips_pkg::FN_SUBU: op_sel = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND:  op_sel = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:   op_sel = mips_pkg::ALU_OR;
          mips_pkg::FN_XOR:  op_sel = mips_pkg::ALU_XOR;
          mips_pkg::FN_NOR:  op_sel = mips_pkg::ALU_NOR;
          mips_pkg::FN_SLT:  op_sel = mips_pkg::ALU_SLT;
          mips_pkg::FN_SLTU: op_sel = mips_pkg::ALU_SLTU;
          mips_pkg::FN_SLL:  op_sel = mips_pkg::ALU_SLL;
          mips_pkg::FN_SRL:  op_sel = mips_pkg::ALU_SRL;
          default:           op_ok  = 1'b0;
        endcase
      end
      mips_pkg::OP_ADDI,
      mips_pkg::OP_ADDIU,
      mips_pkg::OP_LW,
      mips_pkg::OP_SW:    op_sel = mips_pkg::ALU_ADD; // addi without overflow trap
      mips_pkg::OP_BEQ,
      mips_pkg::OP_BNE:   op_sel = mips_pkg::ALU_SUB;
      mips_pkg::OP_ANDI:  op_sel = mips_pkg::ALU_AND;
      mips_pkg::OP_ORI:   op_sel = mips_pkg::ALU_OR;
      mips_pkg::OP_XORI:  op_sel = mips_pkg::ALU_XOR;
      mips_pkg::OP_LUI:   op_sel = mips_pkg::ALU_LUI;
      default:            op_ok  = 1'b0;
    endcase
  end

  always_comb
  begin
    case (op_sel)
      mips_pkg::ALU_ADD:  o_result = i_a + i_b;
      mips_pkg::ALU_SUB:  o_result = i_a - i_b;
      mips_pkg::ALU_AND:  o_result = i_a & i_b;
      mips_pkg::ALU_OR:   o_result = i_a | i_b;
      mips_pkg::ALU_XOR:  o_result = i_a ^ i_b;
      mips_pkg::ALU_NOR:  o_result = ~(i_a | i_b);
      mips_pkg::ALU_SLT:  o_result = {{(mips_pkg::XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      mips_pkg::ALU_SLTU: o_result = {{(mips_pkg::XLEN-1){1'b0}}, i_a < i_b};
      mips_pkg::ALU_SLL:  o_result = i_b << i_shamt;
      mips_pkg::ALU_SRL:  o_result = i_b >> i_shamt;
      mips_pkg::ALU_LUI:
        o_result = {i_b[mips_pkg::IMM_W-1:0], {(mips_pkg::XLEN-mips_pkg::IMM_W){1'b0}}};
      default:            o_result = '0;
    endcase
    if (!op_ok)
      o_result = '0; // unknown funct or opcode
  end

  assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none
`timescale 1ns/1ns

module reg_file
(
  input  wire                         i_clk,
  input  wire                         i_rst_n,
  input  wire  [mips_pkg::REG_AW-1:0] i_ra1,
  input  wire  [mips_pkg::REG_AW-1:0] i_ra2,
  output logic [mips_pkg::XLEN-1:0]   o_rd1,
  output logic [mips_pkg::XLEN-1:0]   o_rd2,
  input  wire                         i_we,
  input  wire  [mips_pkg::REG_AW-1:0] i_wa,
  input  wire  [mips_pkg::XLEN-1:0]   i_wd
);

  logic [mips_pkg::XLEN-1:0] regs [0:mips_pkg::REG_NUM-1];
  logic                      wr_en;

  // writes to $zero and writes during reset are dropped
  assign wr_en = i_rst_n & i_we & (i_wa != '0);

  always_ff @(posedge i_clk)
  begin
    if (wr_en)
      regs[i_wa] <= i_wd;
  end

  assign o_rd1 = (i_ra1 == '0) ? '0 : regs[i_ra1];
  assign o_rd2 = (i_ra2 == '0) ? '0 : regs[i_ra2];

endmodule

`default_nettype wire

// File: hdl/data_mem.sv
`default_nettype none
`timescale 1ns/1ns

module data_mem
(
  input  wire                       i_clk,
  input  wire  [mips_pkg::XLEN-1:0] i_addr,
  input  wire                       i_we,
  input  wire  [mips_pkg::XLEN-1:0] i_wd,
  output logic [mips_pkg::XLEN-1:0] o_rd
);

  logic [mips_pkg::XLEN-1:0]    mem [0:mips_pkg::DMEM_WORDS-1];
  logic [mips_pkg::DMEM_AW-1:0] idx;

  assign idx = i_addr[2 +: mips_pkg::DMEM_AW]; // word index wraps modulo depth

  always_ff @(posedge i_clk)
  begin
    if (i_we)
      mem[idx] <= i_wd;
  end

  assign o_rd = mem[idx];

endmodule

`default_nettype wire

// File: hdl/pc_unit.sv
`default_nettype none
`timescale 1ns/1ns

module pc_unit
(
  input  wire                         i_clk,
  input  wire                         i_rst_n,
  input  wire                         i_beq,
  input  wire                         i_bne,
  input  wire                         i_jump,
  input  wire                         i_zero,
  input  wire  [mips_pkg::XLEN-1:0]   i_imm_sext,
  input  wire  [mips_pkg::JIDX_W-1:0] i_jidx,
  output logic [mips_pkg::XLEN-1:0]   o_pc
);

  logic [mips_pkg::XLEN-1:0] pc_plus4;
  logic [mips_pkg::XLEN-1:0] br_target;
  logic [mips_pkg::XLEN-1:0] j_target;
  logic                      br_taken;

  assign pc_plus4  = o_pc + mips_pkg::PC_STEP;
  assign br_target = pc_plus4 + {i_imm_sext[mips_pkg::XLEN-3:0], 2'b00};
  assign j_target  = {pc_plus4[mips_pkg::XLEN-1 -: 4], i_jidx, 2'b00}; // region of pc+4
  assign br_taken  = (i_beq & i_zero) | (i_bne & ~i_zero);

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      o_pc <= mips_pkg::RESET_PC;
    else if (i_jump)
      o_pc <= j_target;
    else if (br_taken)
      o_pc <= br_target;
    else
      o_pc <= pc_plus4;
  end

endmodule

`default_nettype wire

// File: hdl/mips_core.sv
`default_nettype none
`timescale 1ns/1ns

module mips_core
(
  input  wire                         i_clk,
  input  wire                         i_rst_n,
  input  wire  [mips_pkg::XLEN-1:0]   i_instr,
  output logic [mips_pkg::XLEN-1:0]   o_pc,
  output logic                        o_wb_valid,
  output logic [mips_pkg::REG_AW-1:0] o_wb_addr,
  output logic [mips_pkg::XLEN-1:0]   o_wb_data,
  output logic                        o_illegal
);

  logic [mips_pkg::OP_W-1:0]   opcode;
  logic [mips_pkg::REG_AW-1:0] rs, rt, rd, wa;
  logic [mips_pkg::SH_W-1:0]   shamt;
  logic [mips_pkg::FN_W-1:0]   funct;
  logic [mips_pkg::IMM_W-1:0]  imm;
  logic [mips_pkg::JIDX_W-1:0] jidx;

  logic                        reg_dst, jump, beq, bne, mem_to_reg;
  logic                        mem_write, alu_src_op2, reg_write, ext_op, unknown_command;
  logic [mips_pkg::OP_W-1:0]   alu_op;

  logic [mips_pkg::XLEN-1:0]   imm_sext, imm_ext;
  logic [mips_pkg::XLEN-1:0]   rd1, rd2, alu_b, alu_result, mem_rd, wb_data;
  logic                        zero;

  assign opcode = i_instr[31:26];
  assign rs     = i_instr[25:21];
  assign rt     = i_instr[20:16];
  assign rd     = i_instr[15:11];
  assign shamt  = i_instr[10:6];
  assign funct  = i_instr[5:0];
  assign imm    = i_instr[15:0];
  assign jidx   = i_instr[25:0];

  assign imm_sext = {{(mips_pkg::XLEN-mips_pkg::IMM_W){imm[mips_pkg::IMM_W-1]}}, imm};
  assign imm_ext  = ext_op ? imm_sext : {{(mips_pkg::XLEN-mips_pkg::IMM_W){1'b0}}, imm};

  assign wa      = reg_dst ? rd : rt;
  assign alu_b   = alu_src_op2 ? imm_ext : rd2;
  assign wb_data = mem_to_reg ? mem_rd : alu_result;

  control u_control (
    .i_instr_code      (opcode),
    .o_reg_dst         (reg_dst),
    .o_jump            (jump),
    .o_beq             (beq),
    .o_bne             (bne),
    .o_mem_to_reg      (mem_to_reg),
    .o_alu_op          (alu_op),
    .o_mem_write       (mem_write),
    .o_alu_src_op2     (alu_src_op2),
    .o_reg_write       (reg_write),
    .o_ext_op          (ext_op),
    .o_unknown_command (unknown_command)
  );

  reg_file u_reg_file (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ra1   (rs),
    .i_ra2   (rt),
    .o_rd1   (rd1),
    .o_rd2   (rd2),
    .i_we    (reg_write),
    .i_wa    (wa),
    .i_wd    (wb_data)
  );

  alu u_alu (
    .i_alu_op (alu_op),
    .i_funct  (funct),
    .i_shamt  (shamt),
    .i_a      (rd1),
    .i_b      (alu_b),
    .o_result (alu_result),
    .o_zero   (zero)
  );

  data_mem u_data_mem (
    .i_clk  (i_clk),
    .i_addr (alu_result),
    .i_we   (mem_write & i_rst_n), // hold off stores during reset
    .i_wd   (rd2),
    .o_rd   (mem_rd)
  );

  pc_unit u_pc_unit (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_beq      (beq),
    .i_bne      (bne),
    .i_jump     (jump),
    .i_zero     (zero),
    .i_imm_sext (imm_sext),
    .i_jidx     (jidx),
    .o_pc       (o_pc)
  );

  // retire trace of the instruction committed on this edge
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      o_wb_valid <= 1'b0;
      o_wb_addr  <= '0;
      o_wb_data  <= '0;
      o_illegal  <= 1'b0;
    end
    else
    begin
      o_wb_valid <= reg_write;
      o_wb_addr  <= wa;
      o_wb_data  <= wb_data;
      o_illegal  <= unknown_command;
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_mips_core.sv
`default_nettype none
`timescale 1ns/1ns

module tb_mips_core;

  localparam int MAX_CYCLES = 400; // five tests of up to 70 cycles plus margin

  logic        i_clk;
  logic        i_rst_n;
  logic [31:0] i_instr;
  wire  [31:0] o_pc;
  wire         o_wb_valid;
  wire  [4:0]  o_wb_addr;
  wire  [31:0] o_wb_data;
  wire         o_illegal;

  logic [31:0] imem [0:63];
  logic [31:0] m_regs [0:31];
  logic [31:0] m_mem [0:63];
  logic [31:0] m_pc;
  logic        e_valid;
  logic        e_ill;
  logic [4:0]  e_addr;
  logic [31:0] e_data;
  int          prog_idx;
  int          errors;
  int          cycles;
  integer      seed;

  mips_core DUT (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_instr    (i_instr),
    .o_pc       (o_pc),
    .o_wb_valid (o_wb_valid),
    .o_wb_addr  (o_wb_addr),
    .o_wb_data  (o_wb_data),
    .o_illegal  (o_illegal)
  );

  initial
  begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  always @(posedge i_clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("simulation timed out after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_val(input logic [31:0] act, input logic [31:0] exp, input string msg);
    if (act !== exp)
    begin
      $display("ERR %0t: %s got %h expected %h", $time, msg, act, exp);
      errors = errors + 1;
    end
  endtask

  function automatic logic [31:0] enc_r(input logic [5:0] fn, input int rs, input int rt,
                                        input int rd, input int sh);
    return {mips_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                        input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[prog_idx] = w;
    prog_idx = prog_idx + 1;
  endtask

  // fill with illegal words so a stray fetch shows on the trace
  task automatic clear_program();
    for (int i = 0; i < 64; i++)
      imem[i] = {6'h3f, 26'(i)};
    prog_idx = 0;
  endtask

  task automatic load_const(input int r, input logic [31:0] v);
    emit(enc_i(mips_pkg::OP_LUI, 0, r, int'(v[31:16])));
    emit(enc_i(mips_pkg::OP_ORI, r, r, int'(v[15:0])));
  endtask

  task automatic model_step(input logic [31:0] ins);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sh;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] zx;
    logic [31:0] ea;
    logic [31:0] res;
    logic [31:0] pc4;
    logic [31:0] nxt;
    op  = ins[31:26];
    rs  = ins[25:21];
    rt  = ins[20:16];
    rd  = ins[15:11];
    sh  = ins[10:6];
    fn  = ins[5:0];
    a   = m_regs[rs];
    b   = m_regs[rt];
    sx  = {{16{ins[15]}}, ins[15:0]};
    zx  = {16'h0000, ins[15:0]};
    ea  = a + sx;
    pc4 = m_pc + 32'd4;
    nxt = pc4;
    res = '0;
    e_valid = 1'b0;
    e_ill   = 1'b0;
    e_addr  = rt;
    case (op)
      mips_pkg::OP_RTYPE:
      begin
        e_valid = 1'b1;
        e_addr  = rd;
        case (fn)
          mips_pkg::FN_ADD, mips_pkg::FN_ADDU: res = a + b;
          mips_pkg::FN_SUB, mips_pkg::FN_SUBU: res = a - b;
          mips_pkg::FN_AND:  res = a & b;
          mips_pkg::FN_OR:   res = a | b;
          mips_pkg::FN_XOR:  res = a ^ b;
          mips_pkg::FN_NOR:  res = ~(a | b);
          mips_pkg::FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
          mips_pkg::FN_SLTU: res = {31'b0, a < b};
          mips_pkg::FN_SLL:  res = b << sh;
          mips_pkg::FN_SRL:  res = b >> sh;
          default:           res = '0;
        endcase
      end
      mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU:
      begin
        e_valid = 1'b1;
        res     = a + sx;
      end
      mips_pkg::OP_ANDI:
      begin
        e_valid = 1'b1;
        res     = a & zx;
      end
      mips_pkg::OP_ORI:
      begin
        e_valid = 1'b1;
        res     = a | zx;
      end
      mips_pkg::OP_XORI:
      begin
        e_valid = 1'b1;
        res     = a ^ zx;
      end
      mips_pkg::OP_LUI:
      begin
        e_valid = 1'b1;
        res     = {ins[15:0], 16'h0000};
      end
      mips_pkg::OP_LW:
      begin
        e_valid = 1'b1;
        res     = m_mem[ea[7:2]]; // word index wraps at 64
      end
      mips_pkg::OP_SW:   m_mem[ea[7:2]] = b;
      mips_pkg::OP_BEQ:  if (a == b) nxt = pc4 + {sx[29:0], 2'b00};
      mips_pkg::OP_BNE:  if (a != b) nxt = pc4 + {sx[29:0], 2'b00};
      mips_pkg::OP_J:    nxt = {pc4[31:28], ins[25:0], 2'b00};
      mips_pkg::OP_COP0: nxt = pc4;
      default:           e_ill = 1'b1;
    endcase
    e_data = res;
    if (e_valid && e_addr != 5'd0)
      m_regs[e_addr] = res;
    m_pc = nxt;
  endtask

  task automatic check_trace(input string tag);
    check_val(32'(o_wb_valid), 32'(e_valid), {tag, " wb_valid"});
    check_val(32'(o_illegal), 32'(e_ill), {tag, " illegal"});
    if (e_valid)
    begin
      check_val(32'(o_wb_addr), 32'(e_addr), {tag, " wb_addr"});
      check_val(o_wb_data, e_data, {tag, " wb_data"});
    end
  endtask

  // reset and retire n instructions in lockstep with the model
  task automatic run_program(input int n, input string tag);
    @(negedge i_clk);
    i_rst_n = 1'b0;
    repeat (3) @(negedge i_clk);
    i_rst_n = 1'b1;
    m_pc = '0;
    check_val(o_pc, 32'h0, {tag, " pc after reset"});
    check_val(32'(o_wb_valid), 32'h0, {tag, " wb_valid after reset"});
    check_val(32'(o_illegal), 32'h0, {tag, " illegal after reset"});
    for (int i = 0; i < n; i++)
    begin
      check_val(o_pc, m_pc, {tag, " pc"});
      if (i > 0)
        check_trace(tag);
      i_instr = imem[o_pc[7:2]];
      model_step(i_instr);
      @(negedge i_clk);
    end
    check_trace(tag);
  endtask

  task automatic test_rtype();
    logic [5:0] fns [0:11];
    fns = '{mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_SUBU,
            mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
            mips_pkg::FN_SLT, mips_pkg::FN_SLTU, mips_pkg::FN_SLL, mips_pkg::FN_SRL};
    clear_program();
    load_const(1, $random(seed));
    load_const(2, $random(seed));
    for (int i = 0; i < 12; i++)
      emit(enc_r(fns[i], 1, 2, 3 + i, $random(seed) & 31));
    emit(enc_r(mips_pkg::FN_ADD, 1, 2, 0, 0)); // shows valid but leaves $zero alone
    emit(enc_r(mips_pkg::FN_OR, 0, 0, 15, 0));
    run_program(prog_idx, "rtype");
  endtask

  task automatic test_imm();
    clear_program();
    load_const(1, $random(seed));
    emit(enc_i(mips_pkg::OP_ADDI, 1, 2, -5));
    emit(enc_i(mips_pkg::OP_ADDIU, 1, 3, 'h8001));
    emit(enc_i(mips_pkg::OP_ANDI, 1, 4, 'h8f0f));
    emit(enc_i(mips_pkg::OP_ORI, 1, 5, 'hf000));
    emit(enc_i(mips_pkg::OP_XORI, 1, 6, 'h9999));
    emit(enc_i(mips_pkg::OP_LUI, 0, 7, 'h8765));
    emit(enc_i(mips_pkg::OP_ADDIU, 0, 8, -1));
    run_program(prog_idx, "imm");
  endtask

  task automatic test_mem();
    clear_program();
    for (int r = 2; r < 6; r++)
      load_const(r, $random(seed));
    emit(enc_i(mips_pkg::OP_SW, 0, 2, 'h0000));
    emit(enc_i(mips_pkg::OP_SW, 0, 3, 'h0008));
    emit(enc_i(mips_pkg::OP_SW, 0, 4, 'h007c));
    emit(enc_i(mips_pkg::OP_SW, 0, 5, 'h010c)); // wraps onto word 3
    emit(enc_i(mips_pkg::OP_LW, 0, 9, 'h0000));
    emit(enc_i(mips_pkg::OP_LW, 0, 10, 'h0008));
    emit(enc_i(mips_pkg::OP_LW, 0, 11, 'h007c));
    emit(enc_i(mips_pkg::OP_LW, 0, 12, 'h000c));
    run_program(prog_idx, "mem");
  endtask

  task automatic test_branch();
    clear_program();
    emit(enc_i(mips_pkg::OP_ADDIU, 0, 1, 3));
    emit(enc_i(mips_pkg::OP_ADDIU, 0, 2, 3));
    emit(enc_i(mips_pkg::OP_BEQ, 1, 2, 1));    // taken
    emit(enc_i(mips_pkg::OP_ADDIU, 0, 9, 'h99));
    emit(enc_i(mips_pkg::OP_BNE, 1, 2, 1));    // not taken
    emit(enc_i(mips_pkg::OP_ADDIU, 0, 3, 1));
    emit(enc_i(mips_pkg::OP_BEQ, 1, 3, 5));    // not taken
    emit(enc_i(mips_pkg::OP_BNE, 1, 3, 1));    // taken
    emit(enc_i(mips_pkg::OP_ADDIU, 0, 9, 'h98));
    emit(enc_i(mips_pkg::OP_ADDIU, 1, 1, -1));
    emit(enc_i(mips_pkg::OP_BNE, 1, 0, -2));   // backward loop
    emit({mips_pkg::OP_J, 26'd14});
    emit(enc_i(mips_pkg::OP_ADDIU, 0, 9, 'h97));
    emit(enc_i(mips_pkg::OP_ADDIU, 0, 9, 'h96));
    emit(enc_i(mips_pkg::OP_ADDIU, 0, 4, 'h44));
    run_program(15, "branch");
  endtask

  // ends on an illegal word so the next reset must clear o_illegal
  task automatic test_decode();
    clear_program();
    emit(enc_i(mips_pkg::OP_ADDIU, 0, 1, 7));
    emit(enc_i(6'h3f, 1, 2, 'h1234));
    emit(enc_i(mips_pkg::OP_COP0, 1, 2, 0));
    emit(enc_i(mips_pkg::OP_ADDIU, 1, 2, 1));
    emit(enc_i(6'h01, 1, 3, 'h0010));
    run_program(prog_idx, "decode");
  endtask

  initial
  begin
    i_rst_n = 1'b0;
    i_instr = '0;
    errors  = 0;
    cycles  = 0;
    seed    = 32'he802_9600;
    for (int i = 0; i < 32; i++)
      m_regs[i] = '0;
    test_rtype();
    test_imm();
    test_mem();
    test_decode();
    test_branch();
    $display("checks done, %0d errors", errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hdl/mips_pkg.sv
hdl/control.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/data_mem.sv
hdl/pc_unit.sv
hdl/mips_core.sv
testbench/tb_mips_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f tb.f \
  --top-module tb_mips_core -o sim_tb_mips_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_mips_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
